//--- Makefile
SRCS := $(shell grep -v '^+' files.f) hdl/ooo_config.svh
BIN  := obj_dir/Vtb_ooo_core

.PHONY: all run clean

all: run

$(BIN): files.f $(SRCS)
	verilator --binary --timing --assert -f files.f \
		--top-module tb_ooo_core -o Vtb_ooo_core

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Simulation PASSED'

clean:
	rm -rf obj_dir

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real period_ns = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2.0) clk = ~clk;  // half period per phase
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module tb_ooo_core;
    import ooo_pkg::*;

    typedef inst_t [`OOO_LANES-1:0] group_t;

    localparam int num_groups     = 200;
    localparam int timeout_cycles = 40 * num_groups * `OOO_LANES + 200;

    logic                  clk;
    logic                  rst_n;
    group_t                in_group;
    logic                  in_valid;
    logic                  in_ready;
    wb_t [`OOO_LANES-1:0]  wb;

    logic [31:0]           rng_state;
    logic [`OOO_XLEN-1:0]  arch_regs [`OOO_AREGS];
    wb_t                   exp_q [$];    // expected writebacks, oldest first
    int                    groups_taken;

    tb_clock #(.period_ns(10.0)) i_clock (.clk(clk));

    ooo_core i_ooo_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_group (in_group),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .wb       (wb)
    );

    task automatic end_in_failure();
        $display("Simulation FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("FAILED %s got %h expected %h", name, got, exp);
        end_in_failure();
    endtask

    task automatic plain_error(input string msg);
        $display("ERROR: %s", msg);
        end_in_failure();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // small register range keeps dependencies close together
    function automatic inst_t random_inst();
        inst_t       ins;
        logic [31:0] r;
        logic [31:0] s;
        r = draw_word();
        s = draw_word();
        ins.valid = r[3:0] != 4'd0;    // an empty lane now and then
        ins.rd    = {r[13] & r[14], r[6:4]};
        ins.rs1   = {r[14] & r[15], r[9:7]};
        ins.rs2   = {r[15] & r[13], r[12:10]};
        ins.op    = opcode_e'(r[31:16] % 6);
        ins.imm   = s[15:0];
        return ins;
    endfunction

    function automatic group_t random_group();
        group_t      g;
        logic [31:0] r;
        g[0] = random_inst();
        g[1] = random_inst();
        r    = draw_word();
        if (r[1:0] == 2'd0) begin
            g[1].rs1 = g[0].rd;     // lane 1 reads lane 0 result
        end
        if (r[3:2] == 2'd0) begin
            g[1].rs2 = g[0].rd;
        end
        return g;
    endfunction

    // architectural model, lanes in program order
    task automatic model_group(input group_t g);
        logic [`OOO_XLEN-1:0] a;
        logic [`OOO_XLEN-1:0] b;
        logic [`OOO_XLEN-1:0] v;
        wb_t                  e;
        for (int l = 0; l < `OOO_LANES; l++) begin
            if (g[l].valid) begin
                a = arch_regs[g[l].rs1];
                b = arch_regs[g[l].rs2];
                case (g[l].op)
                    op_li:   v = {{(`OOO_XLEN-16){1'b0}}, g[l].imm};
                    op_add:  v = a + b;
                    op_sub:  v = a - b;
                    op_and:  v = a & b;
                    op_or:   v = a | b;
                    default: v = a ^ b;
                endcase
                e.valid = 1'b1;
                e.rd    = g[l].rd;
                e.value = v;
                exp_q.push_back(e);
                if (g[l].rd != '0) begin
                    arch_regs[g[l].rd] = v;   // r0 stays zero
                end
            end
        end
    endtask

    initial begin : stimulus
        bit pending;
        bit accepted;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_group     = '0;
        rng_state    = 32'd90286;
        groups_taken = 0;
        pending      = 1'b0;
        for (int r = 0; r < `OOO_AREGS; r++) begin
            arch_regs[r] = '0;
        end
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        while (groups_taken < num_groups) begin
            if (!pending) begin
                if (draw_word() % 4 == 0) begin
                    in_valid = 1'b0;    // idle gap
                end else begin
                    in_group = random_group();
                    in_valid = 1'b1;
                    pending  = 1'b1;
                end
            end
            @(negedge clk);
            accepted = in_valid && in_ready;
            @(posedge clk);
            #1;
            if (accepted) begin
                model_group(in_group);
                groups_taken++;
                pending = 1'b0;
            end
        end
        in_valid = 1'b0;
        in_group = '0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);   // room for a stray writeback
        $display("Simulation PASSED");
        $finish;
    end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin : monitor
        wb_t exp_wb;
        if (rst_n) begin
            for (int l = 0; l < `OOO_LANES; l++) begin
                if (groups_taken == 0) begin
                    assert (!wb[l].valid)
                        else plain_error("writeback seen before any group was accepted");
                end
                if (wb[l].valid) begin
                    assert (exp_q.size() > 0)
                        else plain_error("writeback seen with no instruction outstanding");
                    exp_wb = exp_q.pop_front();
                    assert (wb[l].rd == exp_wb.rd)
                        else value_mismatch($sformatf("wb[%0d].rd", l), 32'(wb[l].rd),
                                            32'(exp_wb.rd));
                    assert (wb[l].value == exp_wb.value)
                        else value_mismatch($sformatf("wb[%0d].value", l), wb[l].value,
                                            exp_wb.value);
                end
            end
        end
    end

    a_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !in_ready)
        else plain_error("in_ready high in the first cycle after reset");

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        plain_error("timeout, writebacks still missing");
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/multiport_ram.sv
hdl/rename_stage.sv
hdl/prf.sv
hdl/issue_stage.sv
hdl/execute_stage.sv
hdl/ooo_core.sv
bench/tb_clock.sv
bench/tb_ooo_core.sv

//--- hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module execute_stage (
    input  wire logic                                      clk,
    input  wire logic                                      rst_n,
    input  wire ooo_pkg::iss_bundle_t [`OOO_LANES-1:0]     iss_bundle,
    input  wire logic [`OOO_LANES-1:0][1:0][`OOO_XLEN-1:0] reg_resp,
    output ooo_pkg::exe_bundle_t [`OOO_LANES-1:0]          exe_bundle
);
    import ooo_pkg::*;

    function automatic logic [`OOO_XLEN-1:0] alu(
        input opcode_e              op,
        input logic [`OOO_XLEN-1:0] a,
        input logic [`OOO_XLEN-1:0] b,
        input logic [15:0]          imm
    );
        case (op)
            op_li:   alu = {{(`OOO_XLEN-16){1'b0}}, imm};
            op_add:  alu = a + b;
            op_sub:  alu = a - b;
            op_and:  alu = a & b;
            op_or:   alu = a | b;
            op_xor:  alu = a ^ b;
            default: alu = '0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        for (int l = 0; l < `OOO_LANES; l++) begin
            if (!rst_n) begin
                exe_bundle[l].valid <= 1'b0;
            end else begin
                exe_bundle[l].valid <= iss_bundle[l].valid;
            end
            // result and tags, only meaningful with valid
            exe_bundle[l].rd      <= iss_bundle[l].rd;
            exe_bundle[l].prd     <= iss_bundle[l].prd;
            exe_bundle[l].prd_old <= iss_bundle[l].prd_old;
            exe_bundle[l].value   <= alu(iss_bundle[l].op, reg_resp[l][0],
                                         reg_resp[l][1], iss_bundle[l].imm);
        end
    end

endmodule

`default_nettype wire

//--- hdl/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module issue_stage (
    input  wire logic                                      clk,
    input  wire logic                                      rst_n,
    input  wire ooo_pkg::ren_bundle_t [`OOO_LANES-1:0]     ren_bundle,
    input  wire logic [`OOO_LANES-1:0][1:0]                busy_resp,
    input  wire ooo_pkg::exe_bundle_t [`OOO_LANES-1:0]     exe_bundle,
    output logic                                           take,
    output ooo_pkg::iss_bundle_t [`OOO_LANES-1:0]          iss_bundle
);
    import ooo_pkg::*;

    iss_bundle_t [`OOO_LANES-1:0] held;
    logic [`OOO_LANES-1:0][1:0]   src_busy;
    logic [`OOO_LANES-1:0][1:0]   src_wait;   // busy after this cycle's wakeup
    logic [`OOO_LANES-1:0]        fire;
    logic                         older_ok;

    always_comb begin
        older_ok = 1'b1;
        take     = 1'b1;
        for (int l = 0; l < `OOO_LANES; l++) begin
            for (int s = 0; s < 2; s++) begin
                src_wait[l][s] = src_busy[l][s];
                for (int k = 0; k < `OOO_LANES; k++) begin
                    if (exe_bundle[k].valid && exe_bundle[k].prd == held[l].prs[s]) begin
                        src_wait[l][s] = 1'b0;
                    end
                end
            end
            fire[l]  = held[l].valid && src_wait[l] == 2'b00 && older_ok;
            older_ok = older_ok && (fire[l] || !held[l].valid);  // keep order
            if (held[l].valid && !fire[l]) begin
                take = 1'b0;
            end
            iss_bundle[l]       = held[l];
            iss_bundle[l].valid = fire[l];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int l = 0; l < `OOO_LANES; l++) begin
                held[l].valid <= 1'b0;
            end
        end else begin
            for (int l = 0; l < `OOO_LANES; l++) begin
                if (take) begin
                    held[l].valid   <= ren_bundle[l].valid;
                    held[l].op      <= ren_bundle[l].op;
                    held[l].imm     <= ren_bundle[l].imm;
                    held[l].rd      <= ren_bundle[l].rd;
                    held[l].prs     <= ren_bundle[l].prs;
                    held[l].prd     <= ren_bundle[l].prd;
                    held[l].prd_old <= ren_bundle[l].prd_old;
                    src_busy[l]     <= busy_resp[l];
                end else begin
                    if (fire[l]) begin
                        held[l].valid <= 1'b0;
                    end
                    src_busy[l] <= src_wait[l];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/multiport_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module multiport_ram #(
    parameter int depth  = 48,
    parameter int rports = 4,
    parameter int wports = 2
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire ooo_pkg::preg_t [rports-1:0]         raddr,
    output logic [rports-1:0][`OOO_XLEN-1:0]         rdata,
    input  wire ooo_pkg::preg_t [wports-1:0]         waddr,
    input  wire logic [wports-1:0][`OOO_XLEN-1:0]    wdata,
    input  wire logic [wports-1:0]                   wena
);

    logic [`OOO_XLEN-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int a = 0; a < depth; a++) begin
                mem[a] <= '0;
            end
        end else begin
            for (int w = 0; w < wports; w++) begin
                if (wena[w]) begin
                    mem[waddr[w]] <= wdata[w];  // later port wins
                end
            end
        end
    end

    // combinational read, location 0 is hardwired zero
    always_comb begin
        for (int r = 0; r < rports; r++) begin
            rdata[r] = (raddr[r] == '0) ? '0 : mem[raddr[r]];
        end
    end

endmodule

`default_nettype wire

//--- hdl/ooo_config.svh
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// lanes per instruction group, lane 0 is the oldest
`define OOO_LANES 2

// architectural registers, r0 reads as zero
`define OOO_AREGS 16

// physical registers, p0 is never handed out
`define OOO_PREGS 48

// datapath width
`define OOO_XLEN 32

`endif

//--- hdl/ooo_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module ooo_core (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire ooo_pkg::inst_t [`OOO_LANES-1:0]   in_group,
    input  wire logic                              in_valid,
    output logic                                   in_ready,
    output ooo_pkg::wb_t [`OOO_LANES-1:0]          wb
);
    import ooo_pkg::*;

    ren_bundle_t [`OOO_LANES-1:0]             ren_bundle;
    iss_bundle_t [`OOO_LANES-1:0]             iss_bundle;
    exe_bundle_t [`OOO_LANES-1:0]             exe_bundle;
    logic [`OOO_LANES-1:0][1:0]               busy_resp;
    logic [`OOO_LANES-1:0][1:0][`OOO_XLEN-1:0] reg_resp;
    logic                                     take;

    rename_stage i_rename (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_group   (in_group),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .take       (take),
        .exe_bundle (exe_bundle),
        .ren_bundle (ren_bundle)
    );

    prf i_prf (
        .clk        (clk),
        .rst_n      (rst_n),
        .ren_bundle (ren_bundle),
        .iss_bundle (iss_bundle),
        .exe_bundle (exe_bundle),
        .busy_resp  (busy_resp),
        .reg_resp   (reg_resp)
    );

    issue_stage i_issue (
        .clk        (clk),
        .rst_n      (rst_n),
        .ren_bundle (ren_bundle),
        .busy_resp  (busy_resp),
        .exe_bundle (exe_bundle),
        .take       (take),
        .iss_bundle (iss_bundle)
    );

    execute_stage i_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .iss_bundle (iss_bundle),
        .reg_resp   (reg_resp),
        .exe_bundle (exe_bundle)
    );

    // visible writeback, one per lane
    always_comb begin
        for (int l = 0; l < `OOO_LANES; l++) begin
            wb[l].valid = exe_bundle[l].valid;
            wb[l].rd    = exe_bundle[l].rd;
            wb[l].value = exe_bundle[l].value;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ooo_pkg.sv
`default_nettype none
`include "ooo_config.svh"

package ooo_pkg;

    typedef logic [$clog2(`OOO_AREGS)-1:0] areg_t;
    typedef logic [$clog2(`OOO_PREGS)-1:0] preg_t;

    typedef enum logic [2:0] {
        op_li,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor
    } opcode_e;

    typedef struct packed {
        logic        valid;
        opcode_e     op;
        areg_t       rd;
        areg_t       rs1;
        areg_t       rs2;
        logic [15:0] imm;       // zero-extended for op_li
    } inst_t;

    typedef struct packed {
        logic            valid;
        opcode_e         op;
        logic [15:0]     imm;
        areg_t           rd;
        preg_t [1:0]     prs;   // renamed sources
        preg_t           prd;
        preg_t           prd_old; // freed at writeback
    } ren_bundle_t;

    typedef struct packed {
        logic            valid;
        opcode_e         op;
        logic [15:0]     imm;
        areg_t           rd;
        preg_t [1:0]     prs;
        preg_t           prd;
        preg_t           prd_old;
    } iss_bundle_t;

    typedef struct packed {
        logic                 valid;
        areg_t                rd;
        preg_t                prd;
        preg_t                prd_old;
        logic [`OOO_XLEN-1:0] value;
    } exe_bundle_t;

    typedef struct packed {
        logic                 valid;
        areg_t                rd;
        logic [`OOO_XLEN-1:0] value;
    } wb_t;

endpackage

`default_nettype wire

//--- hdl/prf.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module prf (
    input  wire logic                                      clk,
    input  wire logic                                      rst_n,
    input  wire ooo_pkg::ren_bundle_t [`OOO_LANES-1:0]     ren_bundle,
    input  wire ooo_pkg::iss_bundle_t [`OOO_LANES-1:0]     iss_bundle,
    input  wire ooo_pkg::exe_bundle_t [`OOO_LANES-1:0]     exe_bundle,
    output logic [`OOO_LANES-1:0][1:0]                     busy_resp,
    output logic [`OOO_LANES-1:0][1:0][`OOO_XLEN-1:0]      reg_resp
);
    import ooo_pkg::*;

    logic [`OOO_PREGS-1:0]                   busy;
    preg_t [2*`OOO_LANES-1:0]                raddr;
    logic [2*`OOO_LANES-1:0][`OOO_XLEN-1:0]  rdata;
    preg_t [`OOO_LANES-1:0]                  waddr;
    logic [`OOO_LANES-1:0][`OOO_XLEN-1:0]    wdata;
    logic [`OOO_LANES-1:0]                   wena;

    always_comb begin
        for (int i = 0; i < `OOO_LANES; i++) begin
            for (int s = 0; s < 2; s++) begin
                busy_resp[i][s] = busy[ren_bundle[i].prs[s]];
                for (int j = 0; j < i; j++) begin  // older lane produces it
                    if (ren_bundle[j].valid && ren_bundle[j].rd != '0 &&
                        ren_bundle[i].prs[s] == ren_bundle[j].prd) begin
                        busy_resp[i][s] = 1'b1;
                    end
                end
                for (int j = 0; j < `OOO_LANES; j++) begin  // written back now
                    if (exe_bundle[j].valid && ren_bundle[i].prs[s] == exe_bundle[j].prd) begin
                        busy_resp[i][s] = 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < `OOO_LANES; i++) begin
                if (ren_bundle[i].valid && ren_bundle[i].rd != '0) begin
                    busy[ren_bundle[i].prd] <= 1'b1;
                end
            end
            for (int i = 0; i < `OOO_LANES; i++) begin
                if (exe_bundle[i].valid) begin
                    busy[exe_bundle[i].prd] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `OOO_LANES; i++) begin
            raddr[2*i]   = iss_bundle[i].prs[0];
            raddr[2*i+1] = iss_bundle[i].prs[1];
            waddr[i]     = exe_bundle[i].prd;
            wdata[i]     = exe_bundle[i].value;
            wena[i]      = exe_bundle[i].valid && exe_bundle[i].prd != '0;
        end
    end

    // operand read with writeback bypass
    always_comb begin
        for (int i = 0; i < `OOO_LANES; i++) begin
            for (int s = 0; s < 2; s++) begin
                reg_resp[i][s] = rdata[2*i+s];
                for (int k = 0; k < `OOO_LANES; k++) begin
                    if (wena[k] && waddr[k] == raddr[2*i+s]) begin
                        reg_resp[i][s] = wdata[k];
                    end
                end
                if (raddr[2*i+s] == '0) begin
                    reg_resp[i][s] = '0;
                end
            end
        end
    end

    multiport_ram #(
        .depth  (`OOO_PREGS),
        .rports (2*`OOO_LANES),
        .wports (`OOO_LANES)
    ) i_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (raddr),
        .rdata (rdata),
        .waddr (waddr),
        .wdata (wdata),
        .wena  (wena)
    );

    // rename must have given every real destination a nonzero preg
    for (genvar i = 0; i < `OOO_LANES; i++) begin : g_chk
        a_no_p0_write: assert property (@(posedge clk) disable iff (!rst_n)
            exe_bundle[i].valid && exe_bundle[i].rd != '0 |-> exe_bundle[i].prd != '0);
    end

endmodule

`default_nettype wire

//--- hdl/rename_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module rename_stage (
    input  wire logic                                      clk,
    input  wire logic                                      rst_n,
    input  wire ooo_pkg::inst_t [`OOO_LANES-1:0]           in_group,
    input  wire logic                                      in_valid,
    output logic                                           in_ready,
    input  wire logic                                      take,
    input  wire ooo_pkg::exe_bundle_t [`OOO_LANES-1:0]     exe_bundle,
    output ooo_pkg::ren_bundle_t [`OOO_LANES-1:0]          ren_bundle
);
    import ooo_pkg::*;

    localparam int fl_depth = `OOO_PREGS - `OOO_AREGS;
    localparam int ptr_w    = $clog2(fl_depth);

    preg_t                        map_tab [`OOO_AREGS];
    preg_t                        fl_mem [fl_depth];
    logic [ptr_w-1:0]             fl_head;
    logic [ptr_w-1:0]             fl_tail;
    logic [ptr_w:0]               fl_count;
    logic                         init_done;
    ren_bundle_t [`OOO_LANES-1:0] ren_d;
    logic [`OOO_LANES-1:0]        need;      // lane allocates a preg
    logic [`OOO_LANES-1:0]        ret;       // lane frees a preg
    logic [ptr_w-1:0]             alloc_ptr [`OOO_LANES];
    logic [ptr_w-1:0]             ret_ptr [`OOO_LANES];
    logic [ptr_w:0]               n_alloc;
    logic [ptr_w:0]               n_ret;
    logic                         stall;
    logic                         fire;

    always_comb begin
        n_alloc = '0;
        n_ret   = '0;
        stall   = 1'b0;
        for (int l = 0; l < `OOO_LANES; l++) begin
            need[l]      = in_group[l].valid && in_group[l].rd != '0;
            ret[l]       = exe_bundle[l].valid && exe_bundle[l].prd_old != '0;
            alloc_ptr[l] = fl_head + n_alloc[ptr_w-1:0];
            ret_ptr[l]   = fl_tail + n_ret[ptr_w-1:0];
            n_alloc      = n_alloc + (ptr_w+1)'(need[l]);
            n_ret        = n_ret + (ptr_w+1)'(ret[l]);
            if (ren_bundle[l].valid && !take) begin
                stall = 1'b1;   // issue still busy
            end
        end
    end

    assign in_ready = init_done && !stall && fl_count >= n_alloc;
    assign fire     = in_valid && in_ready;

    // map lookup, older lanes of the same group take priority
    always_comb begin
        for (int l = 0; l < `OOO_LANES; l++) begin
            ren_d[l].valid   = fire && in_group[l].valid;
            ren_d[l].op      = in_group[l].op;
            ren_d[l].imm     = in_group[l].imm;
            ren_d[l].rd      = in_group[l].rd;
            ren_d[l].prd     = need[l] ? fl_mem[alloc_ptr[l]] : '0;
            ren_d[l].prd_old = map_tab[in_group[l].rd];
            ren_d[l].prs[0]  = map_tab[in_group[l].rs1];
            ren_d[l].prs[1]  = map_tab[in_group[l].rs2];
            for (int k = 0; k < l; k++) begin
                if (need[k] && in_group[k].rd == in_group[l].rd) begin
                    ren_d[l].prd_old = ren_d[k].prd;
                end
                if (need[k] && in_group[k].rd == in_group[l].rs1) begin
                    ren_d[l].prs[0] = ren_d[k].prd;
                end
                if (need[k] && in_group[k].rd == in_group[l].rs2) begin
                    ren_d[l].prs[1] = ren_d[k].prd;
                end
            end
            if (in_group[l].op == op_li) begin
                ren_d[l].prs = '0;  // no sources, never waits
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `OOO_AREGS; r++) begin
                map_tab[r] <= preg_t'(r);
            end
            for (int l = 0; l < `OOO_LANES; l++) begin
                ren_bundle[l].valid <= 1'b0;
            end
            init_done <= 1'b0;
            fl_head   <= '0;
            fl_tail   <= '0;
            fl_count  <= '0;
        end else begin
            init_done <= 1'b1;
            if (!init_done) begin
                fl_count <= (ptr_w+1)'(fl_depth);
            end else begin
                fl_count <= fl_count + n_ret - (fire ? n_alloc : '0);
            end
            fl_tail <= fl_tail + n_ret[ptr_w-1:0];
            if (fire) begin
                fl_head <= fl_head + n_alloc[ptr_w-1:0];
                for (int l = 0; l < `OOO_LANES; l++) begin
                    if (need[l]) begin
                        map_tab[in_group[l].rd] <= ren_d[l].prd;   // younger lane wins
                    end
                end
            end
            if (!stall) begin
                ren_bundle <= ren_d;
            end
        end
    end

    // free list starts out as p16..p47
    always_ff @(posedge clk) begin
        if (!init_done) begin
            for (int i = 0; i < fl_depth; i++) begin
                fl_mem[i] <= preg_t'(`OOO_AREGS + i);
            end
        end else begin
            for (int l = 0; l < `OOO_LANES; l++) begin
                if (ret[l]) begin
                    fl_mem[ret_ptr[l]] <= exe_bundle[l].prd_old;
                end
            end
        end
    end

    a_fl_bound: assert property (@(posedge clk) disable iff (!rst_n)
        fl_count <= (ptr_w+1)'(fl_depth));

    // equal pointers mean empty unless the count says full
    a_no_empty_alloc: assert property (@(posedge clk) disable iff (!rst_n)
        fire && n_alloc != '0 |->
            fl_head != fl_tail || fl_count == (ptr_w+1)'(fl_depth));

endmodule

`default_nettype wire
